// ==== hw/dispatch_config.svh ====
/*
 * Dispatch stage configuration
 * Register width, rename bits and queue depths
 */
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// Width of pc and imm
`define DISPATCH_XLEN 64

// Rename bits carried next to each 5-bit architectural register index
`define DISPATCH_RNBIT 2

// Depth of the dispatch queue in front of the dispatcher
`define DISPATCH_FIFO_DP 8

// Depth of every issue buffer, a power of two
`define DISPATCH_ISSUE_DP 4

`endif

// ==== hw/dispatch_pkg.sv ====
/*
 * Dispatch package
 * Operation and unit encodings, the renamed micro-op format
 * and the payloads handed to each issue buffer and the order buffer
 */
`default_nettype none
`include "dispatch_config.svh"

package dispatch_pkg;

	typedef logic [`DISPATCH_XLEN-1:0] xlen_t;
	typedef logic [5+`DISPATCH_RNBIT-1:0] reg_tag_t; // Register index plus rename bits

	// Grouped by class so the unit can be found with range compares
	typedef enum logic [5:0] {
		op_lui, op_auipc,
		op_addi, op_addiw, op_add, op_addw, op_sub, op_subw,
		op_slti, op_sltiu, op_slli, op_slliw, op_sll, op_sllw, op_slt, op_sltu,
		op_srli, op_srliw, op_srai, op_sraiw, op_srl, op_srlw, op_sra, op_sraw,
		op_xori, op_ori, op_andi, op_xor, op_or, op_and,
		op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld,
		op_sb, op_sh, op_sw, op_sd,
		op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci,
		op_jal, op_jalr, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_fence, op_fence_i, op_ecall, op_ebreak
	} micro_op_e;

	typedef enum logic [2:0] {
		unit_alu,
		unit_lsu,
		unit_csr,
		unit_blu,
		unit_oth
	} exe_unit_e;

	typedef struct packed {
		micro_op_e op;
		xlen_t     pc;
		xlen_t     imm;
		logic [5:0] shamt;
		reg_tag_t  rd0;
		reg_tag_t  rs1;
		reg_tag_t  rs2;
	} micro_instr_t;

	typedef struct packed {
		micro_op_e op;
		xlen_t     pc;
		xlen_t     imm;
		logic [5:0] shamt; // Only the ALU consumes the shift amount
		reg_tag_t  rd0;
		reg_tag_t  rs1;
		reg_tag_t  rs2;
	} alu_issue_t;

	typedef struct packed {
		micro_op_e op;
		xlen_t     pc;
		xlen_t     imm;
		reg_tag_t  rd0;
		reg_tag_t  rs1;
		reg_tag_t  rs2;
	} lsu_issue_t;

	typedef struct packed {
		micro_op_e  op;
		xlen_t      pc;
		logic [11:0] imm; // CSR address field
		reg_tag_t   rd0;
		reg_tag_t   rs1;
	} csr_issue_t;

	typedef struct packed {
		micro_op_e op;
		xlen_t     pc;
		xlen_t     imm;
		reg_tag_t  rd0;
		reg_tag_t  rs1;
		reg_tag_t  rs2;
	} blu_issue_t;

	typedef struct packed {
		micro_op_e op;
		xlen_t     pc;
		xlen_t     imm;
		reg_tag_t  rd0;
		reg_tag_t  rs1;
		reg_tag_t  rs2;
	} oth_issue_t;

	typedef struct packed {
		xlen_t    pc;
		reg_tag_t rd0;
	} iorder_info_t;

endpackage

`default_nettype wire

// ==== hw/gen_fifo.sv ====
/*
 * Generic synchronous FIFO
 * Valid/ready on both sides, payload given by a type parameter,
 * push and pop allowed in the same cycle
 */
`timescale 1ns/100ps
`default_nettype none

module gen_fifo #(
	parameter type DT = logic [31:0],
	parameter int  DP = 4
) (
	input  logic CLK,
	input  logic rst,

	input  logic in_valid,
	output logic in_ready,
	input  DT    in_data,

	output logic out_valid,
	input  logic out_ready,
	output DT    out_data
);

	localparam int AW = $clog2(DP);
	localparam logic [AW:0] FULL_CNT = (AW+1)'(DP);

	DT             mem [DP];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          push;
	logic          pop;

	assign in_ready  = (count != FULL_CNT); // Full check ignores a pop in the same cycle
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];

	assign push = in_valid & in_ready;
	assign pop  = out_valid & out_ready;

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // Wraps since DP is a power of two
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/dispatch.sv ====
/*
 * In-order dispatcher
 * Sorts the dispatch queue head to its execution unit and records it
 * in the order buffer, popping only when both receivers accept
 */
`timescale 1ns/100ps
`default_nettype none

module dispatch (
	input  logic                       head_valid,
	output logic                       head_ready,
	input  dispatch_pkg::micro_instr_t head_info,

	output logic                       iorder_valid,
	input  logic                       iorder_ready,
	output dispatch_pkg::iorder_info_t iorder_info,

	output logic                       alu_push_valid,
	input  logic                       alu_push_ready,
	output dispatch_pkg::alu_issue_t   alu_push_info,

	output logic                       lsu_push_valid,
	input  logic                       lsu_push_ready,
	output dispatch_pkg::lsu_issue_t   lsu_push_info,

	output logic                       csr_push_valid,
	input  logic                       csr_push_ready,
	output dispatch_pkg::csr_issue_t   csr_push_info,

	output logic                       blu_push_valid,
	input  logic                       blu_push_ready,
	output dispatch_pkg::blu_issue_t   blu_push_info,

	output logic                       oth_push_valid,
	input  logic                       oth_push_ready,
	output dispatch_pkg::oth_issue_t   oth_push_info
);

	dispatch_pkg::exe_unit_e unit;
	logic                    unit_ready;
	logic                    unit_go;

	// Class groups are contiguous, so the upper bound of each group decides
	always_comb begin
		if (head_info.op <= dispatch_pkg::op_and) begin
			unit = dispatch_pkg::unit_alu;
		end else if (head_info.op <= dispatch_pkg::op_sd) begin
			unit = dispatch_pkg::unit_lsu;
		end else if (head_info.op <= dispatch_pkg::op_csrrci) begin
			unit = dispatch_pkg::unit_csr;
		end else if (head_info.op <= dispatch_pkg::op_bgeu) begin
			unit = dispatch_pkg::unit_blu;
		end else begin
			unit = dispatch_pkg::unit_oth;
		end
	end

	always_comb begin
		case (unit)
			dispatch_pkg::unit_alu: unit_ready = alu_push_ready;
			dispatch_pkg::unit_lsu: unit_ready = lsu_push_ready;
			dispatch_pkg::unit_csr: unit_ready = csr_push_ready;
			dispatch_pkg::unit_blu: unit_ready = blu_push_ready;
			dispatch_pkg::unit_oth: unit_ready = oth_push_ready;
			default:                unit_ready = 1'b0;
		endcase
	end

	// Each side only sees the other side's ready, never its own
	assign iorder_valid = head_valid & unit_ready;
	assign unit_go      = head_valid & iorder_ready;
	assign head_ready   = head_valid & iorder_ready & unit_ready;

	assign alu_push_valid = unit_go & (unit == dispatch_pkg::unit_alu);
	assign lsu_push_valid = unit_go & (unit == dispatch_pkg::unit_lsu);
	assign csr_push_valid = unit_go & (unit == dispatch_pkg::unit_csr);
	assign blu_push_valid = unit_go & (unit == dispatch_pkg::unit_blu);
	assign oth_push_valid = unit_go & (unit == dispatch_pkg::unit_oth);

	assign iorder_info = '{pc: head_info.pc, rd0: head_info.rd0};

	assign alu_push_info = '{
		op: head_info.op, pc: head_info.pc, imm: head_info.imm, shamt: head_info.shamt,
		rd0: head_info.rd0, rs1: head_info.rs1, rs2: head_info.rs2
	};

	assign lsu_push_info = '{
		op: head_info.op, pc: head_info.pc, imm: head_info.imm,
		rd0: head_info.rd0, rs1: head_info.rs1, rs2: head_info.rs2
	};

	assign csr_push_info = '{
		op: head_info.op, pc: head_info.pc, imm: head_info.imm[11:0],
		rd0: head_info.rd0, rs1: head_info.rs1
	};

	assign blu_push_info = '{
		op: head_info.op, pc: head_info.pc, imm: head_info.imm,
		rd0: head_info.rd0, rs1: head_info.rs1, rs2: head_info.rs2
	};

	assign oth_push_info = '{
		op: head_info.op, pc: head_info.pc, imm: head_info.imm,
		rd0: head_info.rd0, rs1: head_info.rs1, rs2: head_info.rs2
	};

endmodule

`default_nettype wire

// ==== hw/dispatch_top.sv ====
/*
 * Dispatch stage top level
 * Dispatch queue, in-order dispatcher and one issue buffer per unit
 */
`timescale 1ns/100ps
`default_nettype none
`include "dispatch_config.svh"

module dispatch_top (
	input  logic                       CLK,
	input  logic                       rst,

	input  logic                       instr_valid,
	output logic                       instr_ready,
	input  dispatch_pkg::micro_instr_t instr_info,

	output logic                       iorder_valid,
	input  logic                       iorder_ready,
	output dispatch_pkg::iorder_info_t iorder_info,

	output logic                       alu_issue_valid,
	input  logic                       alu_issue_ready,
	output dispatch_pkg::alu_issue_t   alu_issue_info,

	output logic                       lsu_issue_valid,
	input  logic                       lsu_issue_ready,
	output dispatch_pkg::lsu_issue_t   lsu_issue_info,

	output logic                       csr_issue_valid,
	input  logic                       csr_issue_ready,
	output dispatch_pkg::csr_issue_t   csr_issue_info,

	output logic                       blu_issue_valid,
	input  logic                       blu_issue_ready,
	output dispatch_pkg::blu_issue_t   blu_issue_info,

	output logic                       oth_issue_valid,
	input  logic                       oth_issue_ready,
	output dispatch_pkg::oth_issue_t   oth_issue_info
);

	logic                       head_valid;
	logic                       head_ready;
	dispatch_pkg::micro_instr_t head_info;

	logic                       alu_push_valid;
	logic                       alu_push_ready;
	dispatch_pkg::alu_issue_t   alu_push_info;
	logic                       lsu_push_valid;
	logic                       lsu_push_ready;
	dispatch_pkg::lsu_issue_t   lsu_push_info;
	logic                       csr_push_valid;
	logic                       csr_push_ready;
	dispatch_pkg::csr_issue_t   csr_push_info;
	logic                       blu_push_valid;
	logic                       blu_push_ready;
	dispatch_pkg::blu_issue_t   blu_push_info;
	logic                       oth_push_valid;
	logic                       oth_push_ready;
	dispatch_pkg::oth_issue_t   oth_push_info;

	gen_fifo #(.DT(dispatch_pkg::micro_instr_t), .DP(`DISPATCH_FIFO_DP)) dispatch_fifo (
		.CLK, .rst,
		.in_valid(instr_valid), .in_ready(instr_ready), .in_data(instr_info),
		.out_valid(head_valid), .out_ready(head_ready), .out_data(head_info)
	);

	dispatch dispatch0 (
		.head_valid, .head_ready, .head_info,
		.iorder_valid, .iorder_ready, .iorder_info,
		.alu_push_valid, .alu_push_ready, .alu_push_info,
		.lsu_push_valid, .lsu_push_ready, .lsu_push_info,
		.csr_push_valid, .csr_push_ready, .csr_push_info,
		.blu_push_valid, .blu_push_ready, .blu_push_info,
		.oth_push_valid, .oth_push_ready, .oth_push_info
	);

	gen_fifo #(.DT(dispatch_pkg::alu_issue_t), .DP(`DISPATCH_ISSUE_DP)) issue_alu (
		.CLK, .rst,
		.in_valid(alu_push_valid), .in_ready(alu_push_ready), .in_data(alu_push_info),
		.out_valid(alu_issue_valid), .out_ready(alu_issue_ready), .out_data(alu_issue_info)
	);

	gen_fifo #(.DT(dispatch_pkg::lsu_issue_t), .DP(`DISPATCH_ISSUE_DP)) issue_lsu (
		.CLK, .rst,
		.in_valid(lsu_push_valid), .in_ready(lsu_push_ready), .in_data(lsu_push_info),
		.out_valid(lsu_issue_valid), .out_ready(lsu_issue_ready), .out_data(lsu_issue_info)
	);

	gen_fifo #(.DT(dispatch_pkg::csr_issue_t), .DP(`DISPATCH_ISSUE_DP)) issue_csr (
		.CLK, .rst,
		.in_valid(csr_push_valid), .in_ready(csr_push_ready), .in_data(csr_push_info),
		.out_valid(csr_issue_valid), .out_ready(csr_issue_ready), .out_data(csr_issue_info)
	);

	gen_fifo #(.DT(dispatch_pkg::blu_issue_t), .DP(`DISPATCH_ISSUE_DP)) issue_blu (
		.CLK, .rst,
		.in_valid(blu_push_valid), .in_ready(blu_push_ready), .in_data(blu_push_info),
		.out_valid(blu_issue_valid), .out_ready(blu_issue_ready), .out_data(blu_issue_info)
	);

	gen_fifo #(.DT(dispatch_pkg::oth_issue_t), .DP(`DISPATCH_ISSUE_DP)) issue_oth (
		.CLK, .rst,
		.in_valid(oth_push_valid), .in_ready(oth_push_ready), .in_data(oth_push_info),
		.out_valid(oth_issue_valid), .out_ready(oth_issue_ready), .out_data(oth_issue_info)
	);

endmodule

`default_nettype wire

// ==== verification/dispatch_tb.sv ====
/*
 * Dispatch stage testbench
 * Random micro-ops and back-pressure checked against an in-order queue model
 */
`timescale 1ns/100ps
`default_nettype none
`include "dispatch_config.svh"

module dispatch_tb;

	localparam int NUM_OPS        = 600;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 20;
	localparam int STALL_AT       = 200;
	localparam int STALL_CYCLES   = 300;

	logic                       CLK;
	logic                       rst;
	logic                       instr_valid;
	logic                       instr_ready;
	dispatch_pkg::micro_instr_t instr_info;
	logic                       iorder_valid;
	logic                       iorder_ready;
	dispatch_pkg::iorder_info_t iorder_info;
	logic [4:0]                 issue_valid; // Indexed by unit code
	logic [4:0]                 issue_ready;
	dispatch_pkg::alu_issue_t   alu_info;
	dispatch_pkg::lsu_issue_t   lsu_info;
	dispatch_pkg::csr_issue_t   csr_info;
	dispatch_pkg::blu_issue_t   blu_info;
	dispatch_pkg::oth_issue_t   oth_info;

	integer                     seed;
	int                         group_base [6] = '{0, 30, 41, 47, 55, 59};
	string                      unit_name [5] = '{"ALU", "LSU", "CSR", "BLU", "OTH"};
	dispatch_pkg::micro_instr_t order_q [$]; // Accepted, not yet in the order buffer
	dispatch_pkg::micro_instr_t wait_q [$];  // Accepted, not yet issued
	dispatch_pkg::micro_instr_t port_view [5];
	int                         in_buf [5];
	int                         buf_now [5];
	logic                       op_seen [64];
	int                         accept_cnt;
	int                         cycle_cnt;
	int                         offered;
	int                         stall_left;
	logic                       stall_done;

	dispatch_top dut0 (
		.CLK, .rst,
		.instr_valid, .instr_ready, .instr_info,
		.iorder_valid, .iorder_ready, .iorder_info,
		.alu_issue_valid(issue_valid[0]), .alu_issue_ready(issue_ready[0]), .alu_issue_info(alu_info),
		.lsu_issue_valid(issue_valid[1]), .lsu_issue_ready(issue_ready[1]), .lsu_issue_info(lsu_info),
		.csr_issue_valid(issue_valid[2]), .csr_issue_ready(issue_ready[2]), .csr_issue_info(csr_info),
		.blu_issue_valid(issue_valid[3]), .blu_issue_ready(issue_ready[3]), .blu_issue_info(blu_info),
		.oth_issue_valid(issue_valid[4]), .oth_issue_ready(issue_ready[4]), .oth_issue_info(oth_info)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Every issue port widened to the micro-op layout, missing fields zero
	always_comb begin
		port_view[0] = '{op: alu_info.op, pc: alu_info.pc, imm: alu_info.imm,
			shamt: alu_info.shamt, rd0: alu_info.rd0, rs1: alu_info.rs1, rs2: alu_info.rs2};
		port_view[1] = '{op: lsu_info.op, pc: lsu_info.pc, imm: lsu_info.imm,
			shamt: '0, rd0: lsu_info.rd0, rs1: lsu_info.rs1, rs2: lsu_info.rs2};
		port_view[2] = '{op: csr_info.op, pc: csr_info.pc, imm: 64'(csr_info.imm),
			shamt: '0, rd0: csr_info.rd0, rs1: csr_info.rs1, rs2: '0};
		port_view[3] = '{op: blu_info.op, pc: blu_info.pc, imm: blu_info.imm,
			shamt: '0, rd0: blu_info.rd0, rs1: blu_info.rs1, rs2: blu_info.rs2};
		port_view[4] = '{op: oth_info.op, pc: oth_info.pc, imm: oth_info.imm,
			shamt: '0, rd0: oth_info.rd0, rs1: oth_info.rs1, rs2: oth_info.rs2};
	end

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("Errors found");
		$fatal(1);
	endtask

	function automatic int unit_of(input int code);
		int u;
		u = 0;
		for (int i = 1; i < 5; i++) begin
			if (code >= group_base[i]) begin
				u = i;
			end
		end
		return u;
	endfunction

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	// A negative unit picks the op from all groups
	function automatic dispatch_pkg::micro_instr_t random_instr(input int u);
		dispatch_pkg::micro_instr_t m;
		int                         code;
		if (u < 0) begin
			code = rand_below(59);
		end else begin
			code = group_base[u] + rand_below(group_base[u+1] - group_base[u]);
		end
		m.op    = dispatch_pkg::micro_op_e'(code[5:0]);
		m.pc    = {$random(seed), $random(seed)};
		m.imm   = {$random(seed), $random(seed)};
		m.shamt = 6'($random(seed));
		m.rd0   = dispatch_pkg::reg_tag_t'($random(seed));
		m.rs1   = dispatch_pkg::reg_tag_t'($random(seed));
		m.rs2   = dispatch_pkg::reg_tag_t'($random(seed));
		return m;
	endfunction

	function automatic dispatch_pkg::micro_instr_t expected_view(
		input dispatch_pkg::micro_instr_t m, input int u);
		dispatch_pkg::micro_instr_t v;
		v = m;
		if (u != 0) begin
			v.shamt = '0;
		end
		if (u == 2) begin
			v.imm = {52'b0, m.imm[11:0]}; // CSR address only
			v.rs2 = '0;
		end
		return v;
	endfunction

	task automatic check_issue(input int u, input logic valid, input logic ready,
		input dispatch_pkg::micro_instr_t got);
		int                         idx;
		dispatch_pkg::micro_instr_t want;
		assert (valid == (buf_now[u] != 0)) else fail_now($sformatf(
			"FAIL %0t: %s issue valid is %0b while %0d are dispatched",
			$time, unit_name[u], valid, buf_now[u]));
		if (valid && ready) begin
			idx = -1;
			for (int i = wait_q.size() - 1; i >= 0; i--) begin
				if (unit_of(int'(wait_q[i].op)) == u) begin
					idx = i; // Ends on the oldest of this class
				end
			end
			assert (idx >= 0) else fail_now($sformatf(
				"FAIL %0t: %s issue transfer with nothing of its class outstanding",
				$time, unit_name[u]));
			assert (unit_of(int'(got.op)) == u) else fail_now($sformatf(
				"FAIL %0t: op %0d of another class on the %s port", $time, got.op, unit_name[u]));
			want = expected_view(wait_q[idx], u);
			assert (got == want) else fail_now($sformatf(
				"FAIL %0t: %s payload %h, expected %h", $time, unit_name[u], got, want));
			wait_q.delete(idx);
			in_buf[u]--;
			op_seen[got.op] = 1'b1;
		end
	endtask

	task automatic drive_readies(input logic all_high);
		iorder_ready = all_high || rand_below(10) < 6;
		for (int u = 0; u < 5; u++) begin
			issue_ready[u] = all_high || rand_below(10) < 6;
		end
		if (stall_left > 0) begin
			issue_ready[3] = 1'b0; // BLU held off to jam the in-order path
		end
	endtask

	always @(posedge CLK) begin
		dispatch_pkg::micro_instr_t want;
		int                         u;
		if (!rst) begin
			buf_now = in_buf;
			for (int i = 0; i < 5; i++) begin
				check_issue(i, issue_valid[i], issue_ready[i], port_view[i]);
			end
			if (iorder_valid && iorder_ready) begin
				assert (order_q.size() > 0) else fail_now($sformatf(
					"FAIL %0t: order-buffer transfer beyond the accepted count", $time));
				want = order_q.pop_front();
				u = unit_of(int'(want.op));
				assert (buf_now[u] < `DISPATCH_ISSUE_DP) else fail_now($sformatf(
					"FAIL %0t: dispatch to the full %s buffer", $time, unit_name[u]));
				assert (iorder_info.pc == want.pc && iorder_info.rd0 == want.rd0)
					else fail_now($sformatf("FAIL %0t: order entry pc %h rd0 %h, expected %h %h",
					$time, iorder_info.pc, iorder_info.rd0, want.pc, want.rd0));
				in_buf[u]++;
			end
			if (instr_valid && instr_ready) begin
				order_q.push_back(instr_info);
				wait_q.push_back(instr_info);
				accept_cnt++;
			end
		end
	end

	always @(posedge CLK) begin
		cycle_cnt++;
		assert (cycle_cnt < TIMEOUT_CYCLES)
			else fail_now("Timeout: the run did not finish all transfers in time");
	end

	initial begin
		dispatch_pkg::micro_instr_t m;
		int                         base;
		int                         missing;
		seed = 89;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr_info = '0;
		iorder_ready = 1'b0;
		issue_ready = '0;
		accept_cnt = 0;
		cycle_cnt = 0;
		offered = 0;
		stall_left = 0;
		stall_done = 1'b0;
		in_buf = '{default: 0};
		op_seen = '{default: 1'b0};
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		assert (issue_valid == '0 && !iorder_valid && instr_ready) else fail_now($sformatf(
			"FAIL %0t: outputs not idle after reset", $time));
		rst = 1'b0;

		// Single instructions into an empty DUT, one per unit
		iorder_ready = 1'b1;
		issue_ready = '1;
		for (int u = 0; u < 5; u++) begin
			m = random_instr(u);
			instr_valid = 1'b1;
			instr_info = m;
			@(negedge CLK);
			instr_valid = 1'b0;
			assert (iorder_valid && !issue_valid[u]) else fail_now($sformatf(
				"FAIL %0t: %s op not at the dispatcher 1 cycle after accept", $time, unit_name[u]));
			@(negedge CLK);
			assert (issue_valid[u]) else fail_now($sformatf(
				"FAIL %0t: %s op not on its port 2 cycles after accept", $time, unit_name[u]));
			@(negedge CLK);
		end

		base = accept_cnt;
		while (accept_cnt < base + NUM_OPS) begin
			if (stall_left > 0) begin
				stall_left--;
				if (stall_left == 0) begin
					assert (!instr_ready && !iorder_valid) else fail_now($sformatf(
						"FAIL %0t: traffic still flowing behind the stalled BLU", $time));
					stall_done = 1'b1;
				end
			end else if (!stall_done && offered >= STALL_AT) begin
				stall_left = STALL_CYCLES;
			end
			drive_readies(1'b0);
			if (!(instr_valid && accept_cnt < base + offered)) begin
				instr_valid = 1'b0;
				if (offered < NUM_OPS && rand_below(10) < 7) begin
					instr_info = random_instr(-1);
					instr_valid = 1'b1;
					offered++;
				end
			end
			@(negedge CLK);
		end

		instr_valid = 1'b0;
		while (wait_q.size() != 0) begin
			drive_readies(1'b1);
			@(negedge CLK);
		end
		missing = 0;
		for (int i = 0; i < 59; i++) begin
			if (!op_seen[i]) begin
				missing++;
			end
		end
		assert (order_q.size() == 0 && missing == 0) begin
			$display("No errors");
			$finish;
		end else begin
			fail_now($sformatf("FAIL %0t: %0d ops never issued, %0d order entries left",
				$time, missing, order_q.size()));
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/dispatch_pkg.sv
hw/gen_fifo.sv
hw/dispatch.sv
hw/dispatch_top.sv
verification/dispatch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the dispatch stage testbench with Verilator and runs it into a log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module dispatch_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vdispatch_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "No errors" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
